/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Luma from zero-filled 8-bit channels, weights 77/150/29 over 256
function automatic logic [7:0] luma_of(input logic [15:0] p);
    int r;
    int g;
    int b;
    r = p[15:11] * 8;
    g = p[10:5] * 4;
    b = p[4:0] * 8;
    return 8'((r * 77 + g * 150 + b * 29) >> 8);
endfunction

function automatic logic in_mask(input logic [15:0] p);
    logic [7:0] l;
    l = luma_of(p);
    return (l > thr_lo_i) && (l <= thr_hi_i);
endfunction

function automatic logic [23:0] expand_565(input logic [15:0] p);
    return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
endfunction

task automatic report_mismatch(input string name, input longint expv, input longint gotv);
    $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expv, gotv);
    $display("TEST FAILED");
    $fatal(1, "Value check failed");
endtask

task automatic report_error(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "Check failed");
endtask

frame_origin: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    new_frame_o |-> (hcount_o == 0 && vcount_o == 0))
    else report_mismatch("hcount_o/vcount_o", 0, {$sampled(vcount_o), $sampled(hcount_o)});

frame_period: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    new_frame_o == (frame_cyc == frame_cycles))
    else report_mismatch("new_frame_o", $sampled(frame_cyc) == frame_cycles,
                         $sampled(new_frame_o));

active_area: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    active_o == (hcount_o < 64 && vcount_o < 48))
    else report_mismatch("active_o", !$sampled(active_o), $sampled(active_o));

// Sync pulses sit in the blanking
hsync_window: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    hsync_o == (hcount_o >= video_pkg::h_sync_start && hcount_o < video_pkg::h_sync_end))
    else report_mismatch("hsync_o", !$sampled(hsync_o), $sampled(hsync_o));

vsync_window: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    vsync_o == (vcount_o >= video_pkg::v_sync_start && vcount_o < video_pkg::v_sync_end))
    else report_mismatch("vsync_o", !$sampled(vsync_o), $sampled(vsync_o));

// Output pixel three cycles behind its coordinates
rgb_match: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    hv[3] |-> rgb_o == rgb_exp)
    else report_mismatch("rgb_o", $sampled(rgb_exp), $sampled(rgb_o));

valid_expected: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    centroid_valid_o |-> pending)
    else report_error("centroid_valid_o pulsed with no frame result pending");

centroid_x_value: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    centroid_valid_o |-> centroid_x_o == exp_x)
    else report_mismatch("centroid_x_o", $sampled(exp_x), $sampled(centroid_x_o));

centroid_y_value: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    centroid_valid_o |-> centroid_y_o == exp_y)
    else report_mismatch("centroid_y_o", $sampled(exp_y), $sampled(centroid_y_o));

centroid_hold: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    !centroid_valid_o |-> (centroid_x_o == last_cx && centroid_y_o == last_cy))
    else report_mismatch("centroid_x_o/centroid_y_o", {$sampled(last_cy), $sampled(last_cx)},
                         {$sampled(centroid_y_o), $sampled(centroid_x_o)});

centroid_latency: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    !(pending && since_nf > 20))
    else report_error("centroid_valid_o did not arrive within 20 cycles of new_frame_o");

`endif

/* bench/tb_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_tracker;

    localparam int frame_cycles   = 4480;
    localparam int last_frame     = 7;
    localparam int timeout_cycles = 8 * frame_cycles + 200;
    localparam int rect_w         = 12;
    localparam int rect_h         = 8;
    localparam logic [15:0] bright_px = {5'd20, 6'd40, 5'd20}; // Luma 160
    localparam logic [15:0] dark_px   = {5'd1, 6'd2, 5'd1};    // Luma 8

    logic                  clk_pixel = 1'b0;
    logic                  recent_reset;
    logic [15:0]           pixel_i;
    logic [7:0]            thr_lo_i;
    logic [7:0]            thr_hi_i;
    video_pkg::view_mode_t mode_i;
    logic [6:0]            hcount_o;
    logic [5:0]            vcount_o;
    logic                  active_o;
    logic                  hsync_o;
    logic                  vsync_o;
    logic                  new_frame_o;
    logic [23:0]           rgb_o;
    logic [6:0]            centroid_x_o;
    logic [5:0]            centroid_y_o;
    logic                  centroid_valid_o;

    // Reference model state
    integer     seed;
    int         fr;
    int         frame_cyc;
    int         since_nf;
    int         cycles;
    int         rect_x;
    int         rect_y;
    int         sum_x;
    int         sum_y;
    int         cnt;
    logic       pending; // Frame result owed by the divider
    logic [6:0] exp_x;
    logic [5:0] exp_y;
    logic [6:0] last_cx;
    logic [5:0] last_cy;

    // Coordinates and pixels as driven, three stages deep
    logic                  hv[1:3];
    logic [6:0]            hh[1:3];
    logic [5:0]            vh[1:3];
    logic                  ah[1:3];
    logic [15:0]           ph[1:3];
    video_pkg::view_mode_t mh[1:3];
    logic [23:0]           rgb_exp;

    tracker_top dut_i (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pixel_i(pixel_i),
        .thr_lo_i(thr_lo_i),
        .thr_hi_i(thr_hi_i),
        .mode_i(mode_i),
        .hcount_o(hcount_o),
        .vcount_o(vcount_o),
        .active_o(active_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .new_frame_o(new_frame_o),
        .rgb_o(rgb_o),
        .centroid_x_o(centroid_x_o),
        .centroid_y_o(centroid_y_o),
        .centroid_valid_o(centroid_valid_o));

    `include "tb_checks.svh"

    always #4 clk_pixel = ~clk_pixel;

    function automatic logic is_rect(input int f);
        return (f == 0) || (f == 2) || (f == 6);
    endfunction

    function automatic logic is_noise(input int f);
        return (f == 3) || (f == 4);
    endfunction

    function automatic video_pkg::view_mode_t mode_for(input int f);
        if (f == 2 || f == 6) return video_pkg::view_crosshair;
        if (is_noise(f)) return video_pkg::view_mask;
        return video_pkg::view_camera;
    endfunction

    always_comb begin
        if (!ah[3]) begin
            rgb_exp = '0;
        end else begin
            case (mh[3])
                video_pkg::view_mask:
                    rgb_exp = in_mask(ph[3]) ? 24'hffffff : 24'h000000;
                video_pkg::view_crosshair:
                    rgb_exp = (hh[3] == last_cx || vh[3] == last_cy) ?
                              video_pkg::crosshair_rgb : expand_565(ph[3]);
                default: rgb_exp = expand_565(ph[3]);
            endcase
        end
    end

    // Pixel source plus the running centroid model
    always @(posedge clk_pixel) begin : drive
        int          nfr;
        logic [15:0] p;
        logic        hit;
        if (recent_reset) begin
            pixel_i   <= '0;
            frame_cyc <= 0;
            since_nf  <= 0;
            fr        <= 0;
            sum_x     <= 0;
            sum_y     <= 0;
            cnt       <= 0;
            pending   <= 1'b0;
            last_cx   <= '0;
            last_cy   <= '0;
            for (int i = 1; i <= 3; i++) hv[i] <= 1'b0;
        end else begin
            nfr = new_frame_o ? fr + 1 : fr;
            if (new_frame_o && is_rect(nfr)) begin
                rect_x = {$random(seed)} % (64 - rect_w + 1);
                rect_y = {$random(seed)} % (48 - rect_h + 1);
            end
            if (is_rect(nfr)) begin
                p = (hcount_o >= rect_x && hcount_o < rect_x + rect_w &&
                     vcount_o >= rect_y && vcount_o < rect_y + rect_h) ? bright_px : dark_px;
            end else if (is_noise(nfr)) begin
                p = 16'($random(seed));
            end else begin
                p = dark_px;
            end
            pixel_i <= p;
            hit = active_o && in_mask(p);

            if (new_frame_o) begin
                pending <= (cnt != 0);
                if (cnt != 0) begin
                    exp_x <= 7'(sum_x / cnt);
                    exp_y <= 6'(sum_y / cnt);
                end
                sum_x    <= hit ? int'(hcount_o) : 0; // Origin pixel opens the new frame
                sum_y    <= hit ? int'(vcount_o) : 0;
                cnt      <= hit ? 1 : 0;
                since_nf <= 0;
            end else begin
                sum_x    <= sum_x + (hit ? int'(hcount_o) : 0);
                sum_y    <= sum_y + (hit ? int'(vcount_o) : 0);
                cnt      <= cnt + (hit ? 1 : 0);
                since_nf <= since_nf + 1;
            end
            if (centroid_valid_o) begin
                pending <= 1'b0;
                last_cx <= exp_x;
                last_cy <= exp_y;
            end
            frame_cyc <= new_frame_o ? 1 : frame_cyc + 1;
            fr        <= nfr;

            // Mode switches deep in vertical blanking
            if (vcount_o == 50 && hcount_o == 0) mode_i <= mode_for(fr + 1);

            hv[1] <= 1'b1;
            hh[1] <= hcount_o;
            vh[1] <= vcount_o;
            ah[1] <= active_o;
            ph[1] <= p;
            mh[1] <= mode_i;
            for (int i = 2; i <= 3; i++) begin
                hv[i] <= hv[i-1];
                hh[i] <= hh[i-1];
                vh[i] <= vh[i-1];
                ah[i] <= ah[i-1];
                ph[i] <= ph[i-1];
                mh[i] <= mh[i-1];
            end
        end
    end

    initial begin
        seed         = 32'hdf8b;
        recent_reset = 1'b1;
        pixel_i      = '0;
        thr_lo_i     = 8'd100;
        thr_hi_i     = 8'd200;
        mode_i       = video_pkg::view_camera;
        rect_x       = {$random(seed)} % (64 - rect_w + 1);
        rect_y       = {$random(seed)} % (48 - rect_h + 1);
        cycles       = 0;
        repeat (5) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        while (!(fr == last_frame && since_nf > 40) && cycles < timeout_cycles) begin
            @(posedge clk_pixel);
            cycles++;
        end
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, frame %0d not reached", cycles, last_frame);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* common/track_pkg.sv */
`default_nettype none

package track_pkg;

    // Luma from weighted channels, weights sum to 256
    localparam int luma_sum_w = 16;
    localparam logic [luma_sum_w-1:0] luma_r_weight = 77;
    localparam logic [luma_sum_w-1:0] luma_g_weight = 150;
    localparam logic [luma_sum_w-1:0] luma_b_weight = 29;
    localparam int luma_shift = 8; // Divide by 256

    // Per-frame accumulators, a full 64x48 mask is 3072 pixels
    localparam int count_w = 12;
    localparam int sum_x_w = 18;
    localparam int sum_y_w = 18;
    localparam int div_w   = count_w * 2 - 1; // Divisor shifted up by count_w-1

    typedef enum logic [1:0] {
        div_idle = 2'd0,
        div_run  = 2'd1, // One quotient bit per cycle
        div_done = 2'd2  // Result strobe
    } div_state_t;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Coordinate and pixel widths
    localparam int hcount_w = 7;
    localparam int vcount_w = 6;
    localparam int rgb565_w = 16; // Incoming frame stream
    localparam int rgb_w    = 24; // Outgoing 8:8:8 pixels

    // Shrunk raster, 64x48 visible inside an 80x56 frame
    localparam logic [hcount_w-1:0] h_active = 64;
    localparam logic [hcount_w-1:0] h_total  = 80;
    localparam logic [vcount_w-1:0] v_active = 48;
    localparam logic [vcount_w-1:0] v_total  = 56;

    // Sync pulses live in the blanking, high for start <= count < end
    localparam logic [hcount_w-1:0] h_sync_start = 68;
    localparam logic [hcount_w-1:0] h_sync_end   = 72;
    localparam logic [vcount_w-1:0] v_sync_start = 50;
    localparam logic [vcount_w-1:0] v_sync_end   = 52;

    localparam logic [rgb_w-1:0] crosshair_rgb = 24'h00ff00; // Full green

    // Output view selection
    typedef enum logic [1:0] {
        view_camera    = 2'd0, // Camera image only
        view_mask      = 2'd1, // Threshold mask in black and white
        view_crosshair = 2'd2  // Camera image with centroid lines
    } view_mode_t;

endpackage

`default_nettype wire

/* hdl/overlay_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module overlay_mux (
    input  wire                                clk_pixel,
    input  wire                                recent_reset,
    input  wire video_pkg::view_mode_t         mode_i,
    input  wire                                mask_i,
    input  wire [video_pkg::hcount_w-1:0]      mask_hcount_i,
    input  wire [video_pkg::vcount_w-1:0]      mask_vcount_i,
    input  wire                                mask_active_i,
    input  wire [video_pkg::rgb565_w-1:0]      pixel_i,
    input  wire [video_pkg::hcount_w-1:0]      centroid_x_i,
    input  wire [video_pkg::vcount_w-1:0]      centroid_y_i,
    input  wire                                centroid_valid_i,
    output logic [video_pkg::rgb_w-1:0]        rgb_o
);

    logic                           have_centroid; // Set by the first result
    logic [video_pkg::hcount_w-1:0] cross_x;
    logic [video_pkg::vcount_w-1:0] cross_y;
    logic [video_pkg::rgb_w-1:0]    camera_rgb;
    logic                           on_cross;

    always_comb begin
        camera_rgb = {pixel_i[15:11], 3'b000, pixel_i[10:5], 2'b00, pixel_i[4:0], 3'b000};
        on_cross   = have_centroid && ((mask_hcount_i == cross_x) || (mask_vcount_i == cross_y));
    end

    always_ff @(posedge clk_pixel) begin
        if (centroid_valid_i) begin
            cross_x <= centroid_x_i;
            cross_y <= centroid_y_i;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            have_centroid <= 1'b0;
            rgb_o         <= '0;
        end else begin
            if (centroid_valid_i) have_centroid <= 1'b1;
            if (!mask_active_i) begin
                rgb_o <= '0; // Blanking stays black
            end else begin
                case (mode_i)
                    video_pkg::view_mask:
                        rgb_o <= mask_i ? {video_pkg::rgb_w{1'b1}} : '0;
                    video_pkg::view_crosshair:
                        rgb_o <= on_cross ? video_pkg::crosshair_rgb : camera_rgb;
                    default: rgb_o <= camera_rgb;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tracker_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tracker_top (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire [video_pkg::rgb565_w-1:0]  pixel_i,
    input  wire [7:0]                      thr_lo_i,
    input  wire [7:0]                      thr_hi_i,
    input  wire video_pkg::view_mode_t     mode_i,
    output logic [video_pkg::hcount_w-1:0] hcount_o,
    output logic [video_pkg::vcount_w-1:0] vcount_o,
    output logic                           active_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           new_frame_o,
    output logic [video_pkg::rgb_w-1:0]    rgb_o,
    output logic [video_pkg::hcount_w-1:0] centroid_x_o,
    output logic [video_pkg::vcount_w-1:0] centroid_y_o,
    output logic                           centroid_valid_o
);

    // Mask stage, two cycles behind the raster
    logic                           mask;
    logic [video_pkg::hcount_w-1:0] mask_hcount;
    logic [video_pkg::vcount_w-1:0] mask_vcount;
    logic                           mask_active;
    logic [video_pkg::rgb565_w-1:0] mask_pixel;

    // Frame totals into the divider
    logic                           div_start;
    logic [track_pkg::sum_x_w-1:0]  sum_x;
    logic [track_pkg::sum_y_w-1:0]  sum_y;
    logic [track_pkg::count_w-1:0]  count;

    video_timing timing_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .hcount_o(hcount_o),
        .vcount_o(vcount_o),
        .active_o(active_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .new_frame_o(new_frame_o));

    luma_threshold luma_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .hcount_i(hcount_o),
        .vcount_i(vcount_o),
        .active_i(active_o),
        .pixel_i(pixel_i),
        .thr_lo_i(thr_lo_i),
        .thr_hi_i(thr_hi_i),
        .mask_o(mask),
        .mask_hcount_o(mask_hcount),
        .mask_vcount_o(mask_vcount),
        .mask_active_o(mask_active),
        .pixel_o(mask_pixel));

    centroid_accum accum_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .new_frame_i(new_frame_o),
        .mask_i(mask),
        .mask_hcount_i(mask_hcount),
        .mask_vcount_i(mask_vcount),
        .div_start_o(div_start),
        .sum_x_o(sum_x),
        .sum_y_o(sum_y),
        .count_o(count));

    centroid_divider divider_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .div_start_i(div_start),
        .sum_x_i(sum_x),
        .sum_y_i(sum_y),
        .count_i(count),
        .centroid_x_o(centroid_x_o),
        .centroid_y_o(centroid_y_o),
        .centroid_valid_o(centroid_valid_o));

    overlay_mux overlay_inst (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .mode_i(mode_i),
        .mask_i(mask),
        .mask_hcount_i(mask_hcount),
        .mask_vcount_i(mask_vcount),
        .mask_active_i(mask_active),
        .pixel_i(mask_pixel),
        .centroid_x_i(centroid_x_o),
        .centroid_y_i(centroid_y_o),
        .centroid_valid_i(centroid_valid_o),
        .rgb_o(rgb_o));

endmodule

`default_nettype wire

/* hdl/video_timing.sv */
`timescale 1ns/100ps
`default_nettype none

module video_timing (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    output logic [video_pkg::hcount_w-1:0] hcount_o,
    output logic [video_pkg::vcount_w-1:0] vcount_o,
    output logic                           active_o,
    output logic                           hsync_o,
    output logic                           vsync_o,
    output logic                           new_frame_o
);

    logic [video_pkg::hcount_w-1:0] h_next;
    logic [video_pkg::vcount_w-1:0] v_next;
    logic                           h_wrap;

    // Next raster position, everything below registers off it
    always_comb begin
        h_wrap = (hcount_o == video_pkg::h_total - 1'b1);
        h_next = h_wrap ? '0 : hcount_o + 1;
        v_next = vcount_o;
        if (h_wrap) begin
            if (vcount_o == video_pkg::v_total - 1'b1) begin
                v_next = '0;
            end else begin
                v_next = vcount_o + 1;
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o    <= '0;
            vcount_o    <= '0;
            active_o    <= 1'b1; // Origin is visible
            hsync_o     <= 1'b0;
            vsync_o     <= 1'b0;
            new_frame_o <= 1'b0;
        end else begin
            hcount_o <= h_next;
            vcount_o <= v_next;
            active_o <= (h_next < video_pkg::h_active) && (v_next < video_pkg::v_active);
            hsync_o  <= (h_next >= video_pkg::h_sync_start) && (h_next < video_pkg::h_sync_end);
            vsync_o  <= (v_next >= video_pkg::v_sync_start) && (v_next < video_pkg::v_sync_end);
            // Strobe with the return to 0,0
            new_frame_o <= (h_next == '0) && (v_next == '0);
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tracker \
    -f sim.f -o tb_tracker_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/tb_tracker_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* sim.f */
+incdir+bench
common/video_pkg.sv
common/track_pkg.sv
hdl/video_timing.sv
tracker/luma_threshold.sv
tracker/centroid_accum.sv
tracker/centroid_divider.sv
hdl/overlay_mux.sv
hdl/tracker_top.sv
bench/tb_tracker.sv

/* tracker/centroid_accum.sv */
`timescale 1ns/100ps
`default_nettype none

module centroid_accum (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire                            new_frame_i,
    input  wire                            mask_i,
    input  wire [video_pkg::hcount_w-1:0]  mask_hcount_i,
    input  wire [video_pkg::vcount_w-1:0]  mask_vcount_i,
    output logic                           div_start_o,
    output logic [track_pkg::sum_x_w-1:0]  sum_x_o,
    output logic [track_pkg::sum_y_w-1:0]  sum_y_o,
    output logic [track_pkg::count_w-1:0]  count_o
);

    logic [track_pkg::sum_x_w-1:0] sum_x, sum_x_nxt, add_x;
    logic [track_pkg::sum_y_w-1:0] sum_y, sum_y_nxt, add_y;
    logic [track_pkg::count_w-1:0] count, count_nxt;

    // Running totals including the pixel on mask_i right now
    always_comb begin
        add_x = '0;
        add_y = '0;
        if (mask_i) begin
            add_x = {{(track_pkg::sum_x_w - video_pkg::hcount_w){1'b0}}, mask_hcount_i};
            add_y = {{(track_pkg::sum_y_w - video_pkg::vcount_w){1'b0}}, mask_vcount_i};
        end
        sum_x_nxt = sum_x + add_x;
        sum_y_nxt = sum_y + add_y;
        count_nxt = mask_i ? count + 1 : count;
    end

    // Frame totals for the divider
    always_ff @(posedge clk_pixel) begin
        if (new_frame_i) begin
            sum_x_o <= sum_x_nxt;
            sum_y_o <= sum_y_nxt;
            count_o <= count_nxt;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x       <= '0;
            sum_y       <= '0;
            count       <= '0;
            div_start_o <= 1'b0;
        end else if (new_frame_i) begin
            sum_x       <= '0;
            sum_y       <= '0;
            count       <= '0;
            div_start_o <= (count_nxt != '0); // Empty frame keeps the old centroid
        end else begin
            sum_x       <= sum_x_nxt;
            sum_y       <= sum_y_nxt;
            count       <= count_nxt;
            div_start_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tracker/centroid_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module centroid_divider (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire                            div_start_i,
    input  wire [track_pkg::sum_x_w-1:0]   sum_x_i,
    input  wire [track_pkg::sum_y_w-1:0]   sum_y_i,
    input  wire [track_pkg::count_w-1:0]   count_i,
    output logic [video_pkg::hcount_w-1:0] centroid_x_o,
    output logic [video_pkg::vcount_w-1:0] centroid_y_o,
    output logic                           centroid_valid_o
);

    track_pkg::div_state_t state;

    logic [track_pkg::div_w-1:0]   rem_x, rem_y, dvsr;
    logic [track_pkg::div_w-1:0]   rem_x_sub, rem_y_sub;
    logic                          ge_x, ge_y;
    logic [track_pkg::count_w-1:0] quot_x, quot_y, quot_x_nxt, quot_y_nxt;
    logic [track_pkg::count_w-1:0] step; // One-hot, top bit marks the last iteration

    // Trial subtract against the shared divisor
    always_comb begin
        ge_x       = (rem_x >= dvsr);
        ge_y       = (rem_y >= dvsr);
        rem_x_sub  = rem_x - dvsr;
        rem_y_sub  = rem_y - dvsr;
        quot_x_nxt = {quot_x[track_pkg::count_w-2:0], ge_x};
        quot_y_nxt = {quot_y[track_pkg::count_w-2:0], ge_y};
    end

    assign centroid_valid_o = (state == track_pkg::div_done);

    // Datapath, the mean is below 64 so count_w quotient bits always suffice
    always_ff @(posedge clk_pixel) begin
        if (state == track_pkg::div_run) begin
            dvsr   <= dvsr >> 1;
            rem_x  <= ge_x ? rem_x_sub : rem_x; // Keep remainder when the trial fails
            rem_y  <= ge_y ? rem_y_sub : rem_y;
            quot_x <= quot_x_nxt;
            quot_y <= quot_y_nxt;
            step   <= step << 1;
        end else if (div_start_i) begin
            dvsr   <= {count_i, {(track_pkg::count_w - 1){1'b0}}};
            rem_x  <= {{(track_pkg::div_w - track_pkg::sum_x_w){1'b0}}, sum_x_i};
            rem_y  <= {{(track_pkg::div_w - track_pkg::sum_y_w){1'b0}}, sum_y_i};
            quot_x <= '0;
            quot_y <= '0;
            step   <= {{(track_pkg::count_w - 1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state        <= track_pkg::div_idle;
            centroid_x_o <= '0;
            centroid_y_o <= '0;
        end else begin
            case (state)
                track_pkg::div_run: begin
                    if (step[track_pkg::count_w-1]) begin
                        state        <= track_pkg::div_done;
                        centroid_x_o <= quot_x_nxt[video_pkg::hcount_w-1:0];
                        centroid_y_o <= quot_y_nxt[video_pkg::vcount_w-1:0];
                    end
                end
                track_pkg::div_idle, track_pkg::div_done: begin
                    state <= div_start_i ? track_pkg::div_run : track_pkg::div_idle;
                end
                default: state <= track_pkg::div_idle;
            endcase
        end
    end

    // Accumulator never overlaps divisions
    start_when_free: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        div_start_i |-> state != track_pkg::div_run);

    start_to_valid: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        div_start_i |-> ##(track_pkg::count_w + 1) centroid_valid_o);

endmodule

`default_nettype wire

/* tracker/luma_threshold.sv */
`timescale 1ns/100ps
`default_nettype none

module luma_threshold (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire [video_pkg::hcount_w-1:0]  hcount_i,
    input  wire [video_pkg::vcount_w-1:0]  vcount_i,
    input  wire                            active_i,
    input  wire [video_pkg::rgb565_w-1:0]  pixel_i,  // Arrives one cycle after its coordinates
    input  wire [7:0]                      thr_lo_i,
    input  wire [7:0]                      thr_hi_i,
    output logic                           mask_o,
    output logic [video_pkg::hcount_w-1:0] mask_hcount_o,
    output logic [video_pkg::vcount_w-1:0] mask_vcount_o,
    output logic                           mask_active_o,
    output logic [video_pkg::rgb565_w-1:0] pixel_o
);

    logic [video_pkg::hcount_w-1:0]    hcount_d;
    logic [video_pkg::vcount_w-1:0]    vcount_d;
    logic                              active_d;
    logic [track_pkg::luma_sum_w-1:0]  ch_r, ch_g, ch_b;
    logic [track_pkg::luma_sum_w-1:0]  luma_sum;
    logic [7:0]                        luma;
    logic                              in_range;

    // Zero-filled 8-bit channels, held in the wide sum format
    always_comb begin
        ch_r     = {8'd0, pixel_i[15:11], 3'b000};
        ch_g     = {8'd0, pixel_i[10:5], 2'b00};
        ch_b     = {8'd0, pixel_i[4:0], 3'b000};
        luma_sum = ch_r * track_pkg::luma_r_weight + ch_g * track_pkg::luma_g_weight
                 + ch_b * track_pkg::luma_b_weight;
        luma     = luma_sum[track_pkg::luma_shift +: 8]; // Right shift by 8
        in_range = (luma > thr_lo_i) && (luma <= thr_hi_i);
    end

    always_ff @(posedge clk_pixel) begin
        hcount_d      <= hcount_i; // Line up with pixel_i
        vcount_d      <= vcount_i;
        mask_hcount_o <= hcount_d;
        mask_vcount_o <= vcount_d;
        pixel_o       <= pixel_i;
        if (recent_reset) begin
            active_d      <= 1'b0;
            mask_active_o <= 1'b0;
            mask_o        <= 1'b0;
        end else begin
            active_d      <= active_i;
            mask_active_o <= active_d;
            mask_o        <= active_d && in_range;
        end
    end

    // Mask only ever marks pixels that were visible two cycles back
    mask_in_active: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        mask_o |-> mask_active_o && $past(active_i, 2));

endmodule

`default_nettype wire
